// ==== src/forth_pkg.sv ====
// command word and stack primitive encodings
// default data width and stack depth
package forth_pkg;

    localparam int DSZ_DEF   = 32;   // data word width
    localparam int DEPTH_DEF = 16;   // entries per stack, top included

    // forth words given with a command strobe
    typedef enum logic [2:0] {
        CMD_LIT    = 3'd0,           // push operand
        CMD_DUP    = 3'd1,           // ( a -- a a )
        CMD_DROP   = 3'd2,           // ( a -- )
        CMD_SWAP   = 3'd3,           // ( n t -- t n )
        CMD_OVER   = 3'd4,           // ( n t -- n t n )
        CMD_TO_R   = 3'd5,           // data top onto return stack
        CMD_R_FROM = 3'd6            // return top back onto data stack
    } forth_cmd_e;

    // primitive ops seen by one stack unit
    typedef enum logic [1:0] {
        SS_NONE = 2'd0,              // idle
        SS_PUSH = 2'd1,              // spill old top, take vi
        SS_POP  = 2'd2,              // refill top from ram
        SS_LOAD = 2'd3               // overwrite top with vi
    } stack_op_e;

endpackage

// ==== src/stack_mem_if.sv ====
// requester side of the shared stack ram
// one instance per stack unit, arbitrated onto the single port
`timescale 1ns/1ps

interface stack_mem_if #(
    parameter int DSZ   = 32,
    parameter int DEPTH = 16
) ();
    localparam int AW = $clog2(DEPTH);

    logic           req;             // access wanted, held until gnt
    logic           we;              // write when high, read otherwise
    logic [AW-1:0]  addr;            // slot within own half
    logic [DSZ-1:0] wdata;           // spilled top
    logic           gnt;             // access taken at this edge
    logic [DSZ-1:0] rdata;           // valid the cycle after gnt

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface

// ==== src/stack_ram.sv ====
// single-port ram with registered read
// lower half holds data stack spills, upper half return stack spills
`timescale 1ns/1ps

module stack_ram #(
    parameter int   DSZ   = 32,
    parameter int   DEPTH = 16,
    localparam int  AW    = $clog2(DEPTH)
) (
    input  logic           clk,
    input  logic [AW:0]    addr,     // {requester, slot}
    input  logic           we,
    input  logic [DSZ-1:0] wdata,
    output logic [DSZ-1:0] rdata
);

    logic [DSZ-1:0] mem [2*DEPTH];   // both halves

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;      // spill
        end
        rdata <= mem[addr];          // read data one cycle later
    end

endmodule

// ==== src/stack_arbiter.sv ====
// round-robin arbiter for the two stack units
// extends slot addresses with the requester index, steers read data back
`timescale 1ns/1ps

module stack_arbiter #(
    parameter int   DSZ   = 32,
    parameter int   DEPTH = 16,
    localparam int  AW    = $clog2(DEPTH)
) (
    input  logic           clk,
    input  logic           rst,
    stack_mem_if.arbiter   ds,       // requester 0
    stack_mem_if.arbiter   rs,       // requester 1
    output logic [AW:0]    ram_addr,
    output logic           ram_we,
    output logic [DSZ-1:0] ram_wdata,
    input  logic [DSZ-1:0] ram_rdata
);

    logic last_rs;                   // return stack won the last grant
    logic ds_rd_q;                   // ds read issued last cycle
    logic rs_rd_q;                   // rs read issued last cycle

    // on contention the one not granted last wins
    assign ds.gnt = ds.req & (~rs.req | last_rs);
    assign rs.gnt = rs.req & (~ds.req | ~last_rs);

    always_comb begin
        if (rs.gnt) begin
            ram_addr  = {1'b1, rs.addr};     // upper half
            ram_wdata = rs.wdata;
        end else begin
            ram_addr  = {1'b0, ds.addr};     // lower half
            ram_wdata = ds.wdata;
        end
        ram_we = (ds.gnt & ds.we) | (rs.gnt & rs.we);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_rs <= 1'b0;
            ds_rd_q <= 1'b0;
            rs_rd_q <= 1'b0;
        end else begin
            if (ds.gnt) begin
                last_rs <= 1'b0;
            end else if (rs.gnt) begin
                last_rs <= 1'b1;
            end
            ds_rd_q <= ds.gnt & ~ds.we;      // remember who reads
            rs_rd_q <= rs.gnt & ~rs.we;
        end
    end

    // registered ram output goes only to the reader of last cycle
    assign ds.rdata = ds_rd_q ? ram_rdata : '0;
    assign rs.rdata = rs_rd_q ? ram_rdata : '0;

endmodule

// ==== src/stack_unit.sv ====
// one stack with cached top and depth counter
// spills the old top on push, refills it from ram on pop
`timescale 1ns/1ps

module stack_unit import forth_pkg::*; #(
    parameter int   DSZ   = DSZ_DEF,
    parameter int   DEPTH = DEPTH_DEF,
    localparam int  AW    = $clog2(DEPTH),
    localparam int  DW    = $clog2(DEPTH + 1)
) (
    input  logic             clk,
    input  logic             rst,
    input  stack_op_e        op,      // one-cycle primitive
    input  logic [DSZ-1:0]   vi,      // push or load value
    output logic [DSZ-1:0]   tos,     // cached top
    output logic [DW-1:0]    depth,   // items incl. top
    output logic             done,    // op finished
    stack_mem_if.requester   mem
);

    typedef enum logic [1:0] {
        U_IDLE,                       // ready for an op
        U_GNT,                        // req up, waiting for arbiter
        U_RD                          // refill data on rdata
    } unit_state_e;

    unit_state_e    state;
    logic [DSZ-1:0] tos_q;            // top register
    logic           done_q;           // registered completion
    logic [DW-1:0]  dm1;              // depth - 1, slot of old top on push
    logic [DW-1:0]  dm2;              // depth - 2, slot of next on pop

    assign dm1 = depth - 1'b1;
    assign dm2 = depth - 2'd2;

    // refill shows up on tos while done pulses
    assign tos  = (state == U_RD) ? mem.rdata : tos_q;
    assign done = done_q | (state == U_RD);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= U_IDLE;
            done_q  <= 1'b0;
            depth   <= '0;
            mem.req <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                U_IDLE: begin
                    case (op)
                        SS_PUSH: begin
                            tos_q <= vi;                    // new top right away
                            depth <= depth + 1'b1;
                            if (depth == '0) begin
                                done_q <= 1'b1;             // nothing to spill
                            end else begin
                                mem.req   <= 1'b1;
                                mem.we    <= 1'b1;
                                mem.addr  <= dm1[AW-1:0];
                                mem.wdata <= tos_q;         // old top out
                                state     <= U_GNT;
                            end
                        end
                        SS_POP: begin
                            if (depth > DW'(1)) begin
                                depth    <= dm1;
                                mem.req  <= 1'b1;
                                mem.we   <= 1'b0;
                                mem.addr <= dm2[AW-1:0];    // next item below top
                                state    <= U_GNT;
                            end else begin
                                depth  <= '0;               // last item gone
                                done_q <= 1'b1;
                            end
                        end
                        SS_LOAD: begin
                            tos_q  <= vi;
                            done_q <= 1'b1;
                        end
                        default: begin
                        end
                    endcase
                end
                U_GNT: begin
                    if (mem.gnt) begin
                        mem.req <= 1'b0;
                        if (mem.we) begin
                            done_q <= 1'b1;                 // spill written
                            state  <= U_IDLE;
                        end else begin
                            state <= U_RD;
                        end
                    end
                end
                U_RD: begin
                    tos_q <= mem.rdata;                     // keep the refill
                    state <= U_IDLE;
                end
                default: state <= U_IDLE;
            endcase
        end
    end

endmodule

// ==== src/stack_sequencer.sv ====
// breaks forth stack words into unit primitives
// depth checks, busy level and fault pulse
`timescale 1ns/1ps

module stack_sequencer import forth_pkg::*; #(
    parameter int   DSZ   = DSZ_DEF,
    parameter int   DEPTH = DEPTH_DEF,
    localparam int  DW    = $clog2(DEPTH + 1)
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           cmd_valid,
    input  forth_cmd_e     cmd,
    input  logic [DSZ-1:0] operand,
    input  logic [DSZ-1:0] ds_tos,
    input  logic [DW-1:0]  ds_depth,
    input  logic           ds_done,
    input  logic [DSZ-1:0] rs_tos,
    input  logic [DW-1:0]  rs_depth,
    input  logic           rs_done,
    output stack_op_e      ds_op,
    output logic [DSZ-1:0] ds_vi,
    output stack_op_e      rs_op,
    output logic [DSZ-1:0] rs_vi,
    output logic           busy,
    output logic           fault
);

    localparam logic [DW-1:0] FULL = DW'(DEPTH);

    typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT} seq_state_e;

    seq_state_e     state;
    forth_cmd_e     word_q;           // word in progress
    logic [1:0]     step;             // primitive index within word
    logic [DSZ-1:0] t_q;              // saved top, or operand for LIT
    logic [DSZ-1:0] n_q;              // top after the first pop
    logic           accept;
    logic           refuse;
    logic           cur_rs;           // step targets the return stack
    logic           cur_last;
    stack_op_e      cur_op;
    logic [DSZ-1:0] cur_vi;
    logic           cur_done;

    assign accept = cmd_valid & (state == S_IDLE);   // strobes while busy dropped
    assign busy   = (state != S_IDLE);

    always_comb begin
        case (cmd)
            CMD_LIT:    refuse = (ds_depth == FULL);
            CMD_DUP:    refuse = (ds_depth == '0) || (ds_depth == FULL);
            CMD_DROP:   refuse = (ds_depth == '0);
            CMD_SWAP:   refuse = (ds_depth < DW'(2));
            CMD_OVER:   refuse = (ds_depth < DW'(2)) || (ds_depth == FULL);
            CMD_TO_R:   refuse = (ds_depth == '0) || (rs_depth == FULL);
            CMD_R_FROM: refuse = (rs_depth == '0) || (ds_depth == FULL);
            default:    refuse = 1'b1;                 // unknown word
        endcase
    end

    always_comb begin
        cur_rs   = 1'b0;
        cur_op   = SS_NONE;
        cur_vi   = t_q;
        cur_last = 1'b1;
        case (word_q)
            CMD_LIT, CMD_DUP: cur_op = SS_PUSH;
            CMD_DROP:         cur_op = SS_POP;
            CMD_SWAP: begin
                cur_last = (step == 2'd2);
                case (step)
                    2'd0:    cur_op = SS_POP;
                    2'd1:    cur_op = SS_LOAD;          // t onto new top
                    default: begin
                        cur_op = SS_PUSH;
                        cur_vi = n_q;
                    end
                endcase
            end
            CMD_OVER: begin
                cur_last = (step == 2'd2);
                case (step)
                    2'd0:    cur_op = SS_POP;
                    2'd1:    cur_op = SS_PUSH;          // t back
                    default: begin
                        cur_op = SS_PUSH;
                        cur_vi = n_q;
                    end
                endcase
            end
            CMD_TO_R: begin
                cur_last = (step == 2'd1);
                cur_rs   = (step == 2'd0);              // rs push, then ds pop
                cur_op   = (step == 2'd0) ? SS_PUSH : SS_POP;
            end
            CMD_R_FROM: begin
                cur_last = (step == 2'd1);
                cur_rs   = (step == 2'd1);              // ds push, then rs pop
                cur_op   = (step == 2'd0) ? SS_PUSH : SS_POP;
            end
            default: begin
            end
        endcase
    end

    assign cur_done = cur_rs ? rs_done : ds_done;
    assign ds_op    = (state == S_ISSUE && !cur_rs) ? cur_op : SS_NONE;
    assign rs_op    = (state == S_ISSUE &&  cur_rs) ? cur_op : SS_NONE;
    assign ds_vi    = cur_vi;
    assign rs_vi    = cur_vi;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            step  <= 2'd0;
            fault <= 1'b0;
        end else begin
            fault <= accept & refuse;                  // one-cycle pulse
            case (state)
                S_IDLE: begin
                    if (accept && !refuse) begin
                        word_q <= cmd;
                        step   <= 2'd0;
                        state  <= S_ISSUE;
                        if (cmd == CMD_LIT) begin
                            t_q <= operand;
                        end else if (cmd == CMD_R_FROM) begin
                            t_q <= rs_tos;
                        end else begin
                            t_q <= ds_tos;
                        end
                    end
                end
                S_ISSUE: state <= S_WAIT;
                S_WAIT: begin
                    if (cur_done) begin
                        if (step == 2'd0) begin
                            n_q <= ds_tos;                 // next item, SWAP and OVER
                        end
                        if (cur_last) begin
                            state <= S_IDLE;
                        end else begin
                            step  <= step + 1'b1;
                            state <= S_ISSUE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== src/forth_stack_top.sv ====
// operand stack subsystem top
// sequencer, data and return stack units, arbiter and shared ram
`timescale 1ns/1ps

module forth_stack_top import forth_pkg::*; #(
    parameter int   DSZ   = DSZ_DEF,
    parameter int   DEPTH = DEPTH_DEF,
    localparam int  AW    = $clog2(DEPTH),
    localparam int  DW    = $clog2(DEPTH + 1)
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           cmd_valid,
    input  forth_cmd_e     cmd,
    input  logic [DSZ-1:0] operand,
    output logic [DSZ-1:0] ds_tos,
    output logic [DW-1:0]  ds_depth,
    output logic [DSZ-1:0] rs_tos,
    output logic [DW-1:0]  rs_depth,
    output logic           busy,
    output logic           fault
);

    stack_op_e      ds_op, rs_op;
    logic [DSZ-1:0] ds_vi, rs_vi;
    logic           ds_done, rs_done;
    logic [AW:0]    ram_addr;
    logic           ram_we;
    logic [DSZ-1:0] ram_wdata, ram_rdata;

    stack_mem_if #(.DSZ(DSZ), .DEPTH(DEPTH)) ds_mem ();   // data stack port
    stack_mem_if #(.DSZ(DSZ), .DEPTH(DEPTH)) rs_mem ();   // return stack port

    stack_sequencer #(.DSZ(DSZ), .DEPTH(DEPTH)) u_seq (
        .clk, .rst, .cmd_valid, .cmd, .operand,
        .ds_tos, .ds_depth, .ds_done, .rs_tos, .rs_depth, .rs_done,
        .ds_op, .ds_vi, .rs_op, .rs_vi, .busy, .fault
    );

    stack_unit #(.DSZ(DSZ), .DEPTH(DEPTH)) u_ds (
        .clk, .rst, .op(ds_op), .vi(ds_vi), .tos(ds_tos),
        .depth(ds_depth), .done(ds_done), .mem(ds_mem.requester)
    );

    stack_unit #(.DSZ(DSZ), .DEPTH(DEPTH)) u_rs (
        .clk, .rst, .op(rs_op), .vi(rs_vi), .tos(rs_tos),
        .depth(rs_depth), .done(rs_done), .mem(rs_mem.requester)
    );

    stack_arbiter #(.DSZ(DSZ), .DEPTH(DEPTH)) u_arb (
        .clk, .rst, .ds(ds_mem.arbiter), .rs(rs_mem.arbiter),
        .ram_addr, .ram_we, .ram_wdata, .ram_rdata
    );

    stack_ram #(.DSZ(DSZ), .DEPTH(DEPTH)) u_ram (
        .clk, .addr(ram_addr), .we(ram_we), .wdata(ram_wdata), .rdata(ram_rdata)
    );

endmodule

// ==== tests/forth_stack_checker.sv ====
// protocol assertions for the stack subsystem
// bound to forth_stack_top
`timescale 1ns/1ps

module forth_stack_checker #(
    parameter int   DEPTH = 16,
    localparam int  DW    = $clog2(DEPTH + 1)
) (
    input logic          clk,
    input logic          rst,
    input logic          cmd_valid,
    input logic          busy,
    input logic          fault,
    input logic [DW-1:0] ds_depth,
    input logic [DW-1:0] rs_depth
);

    int fail_count = 0;              // assertion failures so far

    a_busy_fault: assert property (@(posedge clk) disable iff (rst) !(busy && fault))
        else begin
            fail_count++;
            $error("busy and fault high together");
        end

    a_depth_limit: assert property (@(posedge clk) disable iff (rst)
        (ds_depth <= DW'(DEPTH)) && (rs_depth <= DW'(DEPTH)))
        else begin
            fail_count++;
            $error("stack depth above limit");
        end

    // refusal pulse follows its strobe by one cycle
    a_fault_cause: assert property (@(posedge clk) disable iff (rst) fault |-> $past(cmd_valid))
        else begin
            fail_count++;
            $error("fault without a strobe the cycle before");
        end

endmodule

bind forth_stack_top forth_stack_checker #(.DEPTH(DEPTH)) u_chk (.*);

// ==== tests/forth_stack_tb.sv ====
// directed tests for forth_stack_top
// queue model of data and return stacks, lcg operands
`timescale 1ns/1ps

module forth_stack_tb import forth_pkg::*; ();

    localparam int DSZ     = 32;
    localparam int DEPTH   = 16;
    localparam int DW      = $clog2(DEPTH + 1);
    localparam int TIMEOUT = 50;             // cycles per word

    logic           clk;
    logic           rst;
    logic           cmd_valid;
    forth_cmd_e     cmd;
    logic [DSZ-1:0] operand;
    logic [DSZ-1:0] ds_tos, rs_tos;
    logic [DW-1:0]  ds_depth, rs_depth;
    logic           busy, fault;

    logic [DSZ-1:0] ds_m[$];                 // model with top at the back
    logic [DSZ-1:0] rs_m[$];
    logic [DSZ-1:0] lcg_state = 94383;
    int errors = 0;
    int checks = 0;
    int tests  = 0;

    forth_stack_top #(.DSZ(DSZ), .DEPTH(DEPTH)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [DSZ-1:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic finish_run();
        int afails;
        afails = DUT.u_chk.fail_count;
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests, checks, errors, afails);
        if (errors == 0 && afails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    task automatic end_test(input string name, input int err0);
        tests++;
        $display("test %s: %s", name, (errors == err0) ? "ok" : "errors found");
    endtask

    // strobe one word, optionally a second strobe while busy, then compare with model
    task automatic issue_cmd(input forth_cmd_e c, input logic [DSZ-1:0] v, input bit extra);
        bit refuse;
        bit got_fault;
        bit got_busy;
        int cycles;
        logic [DSZ-1:0] t;
        logic [DSZ-1:0] n;
        case (c)
            CMD_LIT:    refuse = (ds_m.size() == DEPTH);
            CMD_DUP:    refuse = (ds_m.size() == 0) || (ds_m.size() == DEPTH);
            CMD_DROP:   refuse = (ds_m.size() == 0);
            CMD_SWAP:   refuse = (ds_m.size() < 2);
            CMD_OVER:   refuse = (ds_m.size() < 2) || (ds_m.size() == DEPTH);
            CMD_TO_R:   refuse = (ds_m.size() == 0) || (rs_m.size() == DEPTH);
            default:    refuse = (rs_m.size() == 0) || (ds_m.size() == DEPTH);
        endcase
        @(posedge clk);
        #5;
        cmd_valid = 1'b1;
        cmd       = c;
        operand   = v;
        @(posedge clk);
        #5;
        cmd_valid = 1'b0;
        got_fault = fault;                   // pulse lives one cycle only
        got_busy  = busy;
        if (extra && !refuse) begin
            cmd_valid = 1'b1;                // dropped while busy is high
            cmd       = (c == CMD_LIT) ? CMD_DROP : CMD_LIT;
            operand   = ~v;
            @(posedge clk);
            #5;
            cmd_valid = 1'b0;
        end
        cycles = 0;
        while (busy && cycles < TIMEOUT) begin
            @(posedge clk);
            #5;
            cycles++;
        end
        if (busy) begin
            $display("timeout: busy still high %0d cycles after %s", TIMEOUT, c.name());
            errors++;
            finish_run();
        end else begin
            if (!refuse) begin
                case (c)
                    CMD_LIT:  ds_m.push_back(v);
                    CMD_DUP:  ds_m.push_back(ds_m[$]);
                    CMD_DROP: t = ds_m.pop_back();
                    CMD_SWAP: begin
                        t = ds_m.pop_back();
                        n = ds_m.pop_back();
                        ds_m.push_back(t);
                        ds_m.push_back(n);
                    end
                    CMD_OVER: ds_m.push_back(ds_m[$-1]);
                    CMD_TO_R: rs_m.push_back(ds_m.pop_back());
                    default:  ds_m.push_back(rs_m.pop_back());
                endcase
            end
            checks++;
            if (got_fault != refuse) begin
                $display("ERROR @%0t: %s fault %0b expected %0b", $time, c.name(),
                         got_fault, refuse);
                errors++;
            end
            if (got_busy == refuse) begin
                $display("ERROR @%0t: %s busy %0b after strobe", $time, c.name(), got_busy);
                errors++;
            end
            if (ds_depth != ds_m.size() || rs_depth != rs_m.size()) begin
                $display("ERROR @%0t: %s depths ds %0d rs %0d expected ds %0d rs %0d", $time,
                         c.name(), ds_depth, rs_depth, ds_m.size(), rs_m.size());
                errors++;
            end
            if (ds_m.size() > 0 && ds_tos !== ds_m[$]) begin
                $display("ERROR @%0t: %s ds_tos %h expected %h", $time, c.name(), ds_tos, ds_m[$]);
                errors++;
            end
            if (rs_m.size() > 0 && rs_tos !== rs_m[$]) begin
                $display("ERROR @%0t: %s rs_tos %h expected %h", $time, c.name(), rs_tos, rs_m[$]);
                errors++;
            end
        end
    endtask

    task automatic drain_all();
        while (rs_m.size() > 0) issue_cmd(CMD_R_FROM, '0, 1'b0);
        while (ds_m.size() > 0) issue_cmd(CMD_DROP, '0, 1'b0);
    endtask

    task automatic reset_state();
        int err0;
        err0 = errors;
        checks++;
        if (ds_depth != '0 || rs_depth != '0 || busy || fault) begin
            $display("ERROR @%0t: after reset ds %0d rs %0d busy %0b fault %0b", $time,
                     ds_depth, rs_depth, busy, fault);
            errors++;
        end
        end_test("reset", err0);
    endtask

    task automatic fill_and_drain();
        int err0;
        err0 = errors;
        repeat (DEPTH) issue_cmd(CMD_LIT, lcg_next(), 1'b0);
        repeat (DEPTH) issue_cmd(CMD_DROP, '0, 1'b0);     // tops come back reversed
        end_test("fill_drain", err0);
    endtask

    task automatic shuffle_words();
        int err0;
        err0 = errors;
        repeat (3) issue_cmd(CMD_LIT, lcg_next(), 1'b0);
        issue_cmd(CMD_DUP, '0, 1'b0);
        issue_cmd(CMD_SWAP, '0, 1'b0);
        issue_cmd(CMD_OVER, '0, 1'b0);
        issue_cmd(CMD_LIT, lcg_next(), 1'b0);
        issue_cmd(CMD_SWAP, '0, 1'b0);
        issue_cmd(CMD_OVER, '0, 1'b0);
        issue_cmd(CMD_DUP, '0, 1'b0);
        issue_cmd(CMD_SWAP, '0, 1'b0);
        drain_all();                                      // whole order checked by drops
        end_test("shuffle", err0);
    endtask

    task automatic return_transfer();
        int err0;
        err0 = errors;
        repeat (5) begin
            issue_cmd(CMD_LIT, lcg_next(), 1'b0);
            issue_cmd(CMD_TO_R, '0, 1'b0);               // both halves get spills
            issue_cmd(CMD_LIT, lcg_next(), 1'b0);
        end
        issue_cmd(CMD_R_FROM, '0, 1'b0);
        issue_cmd(CMD_LIT, lcg_next(), 1'b0);
        issue_cmd(CMD_TO_R, '0, 1'b0);
        issue_cmd(CMD_TO_R, '0, 1'b0);
        drain_all();
        end_test("return_stack", err0);
    endtask

    task automatic refused_words();
        int err0;
        err0 = errors;
        issue_cmd(CMD_DROP, '0, 1'b0);                    // empty data stack
        issue_cmd(CMD_R_FROM, '0, 1'b0);                  // empty return stack
        issue_cmd(CMD_LIT, lcg_next(), 1'b0);
        issue_cmd(CMD_SWAP, '0, 1'b0);                    // one item only
        issue_cmd(CMD_OVER, '0, 1'b0);
        repeat (DEPTH - 1) issue_cmd(CMD_LIT, lcg_next(), 1'b0);
        issue_cmd(CMD_LIT, lcg_next(), 1'b0);             // full
        issue_cmd(CMD_DUP, '0, 1'b0);
        issue_cmd(CMD_OVER, '0, 1'b0);
        drain_all();
        end_test("refusals", err0);
    endtask

    task automatic busy_strobes();
        int err0;
        err0 = errors;
        issue_cmd(CMD_LIT, lcg_next(), 1'b1);
        issue_cmd(CMD_LIT, lcg_next(), 1'b1);
        issue_cmd(CMD_DUP, '0, 1'b1);
        issue_cmd(CMD_SWAP, '0, 1'b1);
        issue_cmd(CMD_TO_R, '0, 1'b1);
        issue_cmd(CMD_R_FROM, '0, 1'b1);
        while (ds_m.size() > 0) issue_cmd(CMD_DROP, '0, 1'b1);
        end_test("busy_ignore", err0);
    endtask

    initial begin
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = CMD_LIT;
        operand   = '0;
        repeat (2) @(posedge clk);
        #5;
        rst = 1'b0;
        reset_state();
        fill_and_drain();
        shuffle_words();
        return_transfer();
        refused_words();
        busy_strobes();
        finish_run();
    end

endmodule

// ==== forth_stack.f ====
src/forth_pkg.sv
src/stack_mem_if.sv
src/stack_ram.sv
src/stack_arbiter.sv
src/stack_unit.sv
src/stack_sequencer.sv
src/forth_stack_top.sv
tests/forth_stack_checker.sv
tests/forth_stack_tb.sv

// ==== Bender.yml ====
package:
  name: forth_stack

sources:
  - src/forth_pkg.sv
  - src/stack_mem_if.sv
  - src/stack_ram.sv
  - src/stack_arbiter.sv
  - src/stack_unit.sv
  - src/stack_sequencer.sv
  - src/forth_stack_top.sv
  - target: test
    files:
      - tests/forth_stack_checker.sv
      - tests/forth_stack_tb.sv
